// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing -j 0
LINTFLAGS = --lint-only --timing
TOP       = tb_dma_top
FILELIST  = list.f
OBJ_DIR   = obj_dir
PASS_MSG  = TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: list.f
source/dma_pkg.sv
source/dma_fifo.sv
source/dma_csr.sv
source/dma_rd_src.sv
source/dma_wr_dest.sv
source/dma_mem_arb.sv
source/dma_top.sv
test/tb_dma_top.sv

// File: source/dma_csr.sv
`default_nettype none
/* CSR block of the copy DMA. Stages descriptors, pushes them on go,
   holds stop and overflow, counts completions and serves status reads */
module dma_csr (
    input  wire                     clk,
    input  wire                     rst_n,
    // Host strobe bus
    input  wire                     csr_wr,
    input  wire                     csr_rd,
    input  wire dma_pkg::csr_addr_t csr_addr,
    input  wire dma_pkg::data_t     csr_wdata,
    output dma_pkg::data_t          csr_rdata,
    // Descriptor FIFO write side
    output logic                    desc_push,
    output dma_pkg::dma_desc_t      desc_out,
    input  wire                     desc_full,
    input  wire                     desc_empty,
    input  wire                     data_empty,
    // Engine control and status
    output logic                    stop,
    input  wire                     rd_busy,
    input  wire                     wr_busy,
    input  wire                     done,
    input  wire                     word_written
);
    import dma_pkg::*;

    dma_desc_t   stage_q;
    logic        stop_q;
    logic        overflow_q;
    data_t       done_cnt_q;
    data_t       word_cnt_q;
    dma_status_t status;
    logic        go;

    // ==============================
    // Go and descriptor push
    // ==============================
    assign go        = csr_wr && (csr_addr == CSR_CONTROL) && csr_wdata[CTRL_GO_BIT];
    // Drop the push when the FIFO has no room
    assign desc_push = go && !desc_full;
    assign desc_out  = stage_q;
    assign stop      = stop_q;

    // Busy from either engine
    always_comb begin
        status.busy            = rd_busy || wr_busy;
        status.desc_fifo_full  = desc_full;
        status.desc_fifo_empty = desc_empty;
        status.data_fifo_empty = data_empty;
        status.overflow        = overflow_q;
    end

    // ==============================
    // Registers
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_q    <= '0;
            stop_q     <= 1'b0;
            overflow_q <= 1'b0;
        end else if (csr_wr) begin
            case (csr_addr)
                CSR_CONTROL: stop_q       <= csr_wdata[CTRL_STOP_BIT];
                CSR_SRC:     stage_q.src  <= csr_wdata[ADDR_W-1:0];
                CSR_DEST:    stage_q.dest <= csr_wdata[ADDR_W-1:0];
                CSR_LEN:     stage_q.len  <= csr_wdata[LEN_W-1:0];
                // Any status write clears the sticky bit
                CSR_STATUS:  overflow_q   <= 1'b0;
                default:     ;
            endcase
            if (go && desc_full) begin
                overflow_q <= 1'b1;
            end
        end
    end

    // Completion counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_cnt_q <= '0;
            word_cnt_q <= '0;
        end else begin
            if (done) begin
                done_cnt_q <= done_cnt_q + data_t'(1);
            end
            if (word_written) begin
                word_cnt_q <= word_cnt_q + data_t'(1);
            end
        end
    end

    // Read data one cycle after csr_rd, held until the next read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csr_rdata <= '0;
        end else if (csr_rd) begin
            case (csr_addr)
                CSR_CONTROL:    csr_rdata <= data_t'(stop_q) << CTRL_STOP_BIT;
                CSR_SRC:        csr_rdata <= data_t'(stage_q.src);
                CSR_DEST:       csr_rdata <= data_t'(stage_q.dest);
                CSR_LEN:        csr_rdata <= data_t'(stage_q.len);
                CSR_STATUS:     csr_rdata <= data_t'(status);
                CSR_DONE_COUNT: csr_rdata <= done_cnt_q;
                CSR_WORD_COUNT: csr_rdata <= word_cnt_q;
                default:        csr_rdata <= '0;
            endcase
        end
    end

endmodule
`default_nettype wire

// File: source/dma_fifo.sv
`default_nettype none
/* Register-based synchronous FIFO with a combinational head word.
   Sized by WIDTH and DEPTH for descriptors, commands and copy data */
module dma_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           push,
    input  wire [WIDTH-1:0]               wdata,
    input  wire                           pop,
    output logic [WIDTH-1:0]              rdata,
    output logic                          full,
    output logic                          empty,
    output logic [$clog2(DEPTH+1)-1:0]    free
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH+1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Ignore push on full and pop on empty
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign free  = CNT_W'(DEPTH) - count;
    // Head word straight from storage
    assign rdata = mem[rd_ptr];

    // Storage array
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // Pointers wrap at DEPTH-1, count tracks occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            // Simultaneous push and pop leaves count alone
            if (do_push && !do_pop) begin
                count <= count + CNT_W'(1);
            end else if (do_pop && !do_push) begin
                count <= count - CNT_W'(1);
            end
        end
    end

endmodule
`default_nettype wire

// File: source/dma_mem_arb.sv
`default_nettype none
/* Round-robin arbiter that puts the read and write engines on the single
   memory port. Grants come back in the same cycle as the request */
module dma_mem_arb (
    input  wire                 clk,
    input  wire                 rst_n,
    // Read engine
    input  wire                 rd_req,
    input  wire dma_pkg::addr_t rd_addr,
    output logic                rd_gnt,
    // Write engine
    input  wire                 wr_req,
    input  wire dma_pkg::addr_t wr_addr,
    input  wire dma_pkg::data_t wr_data,
    output logic                wr_gnt,
    // Memory port
    output logic                mem_en,
    output logic                mem_we,
    output dma_pkg::addr_t      mem_addr,
    output dma_pkg::data_t      mem_wdata
);
    import dma_pkg::*;

    arb_state_t prio_q;

    // A lone request wins, a tie goes to the pointer
    assign rd_gnt = rd_req && (!wr_req || (prio_q == PRIO_RD));
    assign wr_gnt = wr_req && (!rd_req || (prio_q == PRIO_WR));

    // Port follows whoever holds the grant
    assign mem_en    = rd_gnt || wr_gnt;
    assign mem_we    = wr_gnt;
    assign mem_addr  = wr_gnt ? wr_addr : rd_addr;
    assign mem_wdata = wr_data;

    // Pointer moves to the engine that was not served
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio_q <= PRIO_RD;
        end else if (rd_gnt) begin
            prio_q <= PRIO_WR;
        end else if (wr_gnt) begin
            prio_q <= PRIO_RD;
        end
    end

endmodule
`default_nettype wire

// File: source/dma_pkg.sv
`default_nettype none
/* Shared types and constants of the copy DMA. Every block imports this
   package inside its body and uses scoped names in its port list */
package dma_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int ADDR_W     = 16;
    localparam int DATA_W     = 32;
    localparam int LEN_W      = 16;
    localparam int CSR_ADDR_W = 3;

    // FIFO depths
    localparam int DESC_FIFO_DEPTH = 4;
    localparam int CMD_FIFO_DEPTH  = 4;
    localparam int DATA_FIFO_DEPTH = 8;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [LEN_W-1:0]      len_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    // Free-entry count of the data FIFO
    typedef logic [$clog2(DATA_FIFO_DEPTH+1)-1:0] data_cnt_t;

    // One copy job, 48 bits
    typedef struct packed {
        addr_t src;
        addr_t dest;
        len_t  len;
    } dma_desc_t;

    // Status register layout, busy in the top bit
    typedef struct packed {
        logic busy;
        logic desc_fifo_full;
        logic desc_fifo_empty;
        logic data_fifo_empty;
        logic overflow;
    } dma_status_t;

    // ==============================
    // CSR map
    // ==============================
    localparam csr_addr_t CSR_CONTROL    = 3'd0;
    localparam csr_addr_t CSR_SRC        = 3'd1;
    localparam csr_addr_t CSR_DEST       = 3'd2;
    localparam csr_addr_t CSR_LEN        = 3'd3;
    localparam csr_addr_t CSR_STATUS     = 3'd4;
    localparam csr_addr_t CSR_DONE_COUNT = 3'd5;
    localparam csr_addr_t CSR_WORD_COUNT = 3'd6;

    // Control register bits
    localparam int CTRL_GO_BIT   = 0;
    localparam int CTRL_STOP_BIT = 1;

    // State encodings
    typedef enum logic {PRIO_RD, PRIO_WR} arb_state_t;
    typedef enum logic {RD_IDLE, RD_ISSUE} rd_state_t;
    typedef enum logic {WR_IDLE, WR_COPY} wr_state_t;

endpackage
`default_nettype wire

// File: source/dma_rd_src.sv
`default_nettype none
/* Read engine of the copy DMA. Pops descriptors, forwards them as write
   commands and streams source words into the data FIFO */
module dma_rd_src (
    input  wire                     clk,
    input  wire                     rst_n,
    // Descriptor FIFO head
    input  wire dma_pkg::dma_desc_t desc_in,
    input  wire                     desc_empty,
    input  wire                     stop,
    output logic                    desc_pop,
    // Command FIFO toward the write engine
    output logic                    cmd_push,
    input  wire                     cmd_full,
    // Memory read request
    output logic                    rd_req,
    output dma_pkg::addr_t          rd_addr,
    input  wire                     rd_gnt,
    input  wire dma_pkg::data_t     mem_rdata,
    // Data FIFO write side
    output logic                    data_push,
    output dma_pkg::data_t          data_wdata,
    input  wire dma_pkg::data_cnt_t data_free,
    output logic                    busy
);
    import dma_pkg::*;

    rd_state_t state_q;
    addr_t     addr_q;
    len_t      remain_q;
    logic      in_flight_q;
    logic      take;
    logic      issued;

    // Take a descriptor only if the command FIFO can hold it too
    assign take     = (state_q == RD_IDLE) && !desc_empty && !stop && !cmd_full;
    assign desc_pop = take;
    assign cmd_push = take;

    // Keep a free slot for every read still in flight
    assign rd_req  = (state_q == RD_ISSUE) && (data_free > data_cnt_t'(in_flight_q));
    assign rd_addr = addr_q;
    assign issued  = rd_req && rd_gnt;

    // Read data arrives one cycle after the grant
    assign data_push  = in_flight_q;
    assign data_wdata = mem_rdata;

    assign busy = (state_q != RD_IDLE) || in_flight_q;

    // ==============================
    // Read FSM
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= RD_IDLE;
            addr_q      <= '0;
            remain_q    <= '0;
            in_flight_q <= 1'b0;
        end else begin
            in_flight_q <= issued;
            case (state_q)
                RD_IDLE: begin
                    // Zero length passes through with no reads
                    if (take && (desc_in.len != '0)) begin
                        addr_q   <= desc_in.src;
                        remain_q <= desc_in.len;
                        state_q  <= RD_ISSUE;
                    end
                end
                RD_ISSUE: begin
                    if (issued) begin
                        addr_q   <= addr_q + addr_t'(1);
                        remain_q <= remain_q - len_t'(1);
                        // Last word issued
                        if (remain_q == len_t'(1)) begin
                            state_q <= RD_IDLE;
                        end
                    end
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

endmodule
`default_nettype wire

// File: source/dma_top.sv
`default_nettype none
/* Top level of the descriptor-driven copy DMA. Joins the CSR block, the
   three FIFOs, both engines and the memory arbiter */
module dma_top (
    input  wire                     clk,
    input  wire                     rst_n,
    // CSR bus
    input  wire                     csr_wr,
    input  wire                     csr_rd,
    input  wire dma_pkg::csr_addr_t csr_addr,
    input  wire dma_pkg::data_t     csr_wdata,
    output dma_pkg::data_t          csr_rdata,
    // Memory port
    output logic                    mem_en,
    output logic                    mem_we,
    output dma_pkg::addr_t          mem_addr,
    output dma_pkg::data_t          mem_wdata,
    input  wire dma_pkg::data_t     mem_rdata
);
    import dma_pkg::*;

    // Descriptor path
    dma_desc_t desc_stage;
    dma_desc_t desc_head;
    logic      desc_push;
    logic      desc_pop;
    logic      desc_full;
    logic      desc_empty;
    // Command path
    dma_desc_t cmd_head;
    logic      cmd_push;
    logic      cmd_pop;
    logic      cmd_full;
    logic      cmd_empty;
    // Copy data path
    data_t     data_wdata;
    data_t     data_head;
    data_cnt_t data_free;
    logic      data_push;
    logic      data_pop;
    logic      data_empty;
    // Arbiter side
    addr_t     rd_addr;
    addr_t     wr_addr;
    data_t     wr_data;
    logic      rd_req;
    logic      rd_gnt;
    logic      wr_req;
    logic      wr_gnt;
    // Control and status
    logic      stop;
    logic      rd_busy;
    logic      wr_busy;
    logic      done;
    logic      word_written;

    // ==============================
    // Host side
    // ==============================
    dma_csr dma_csr_inst (
        .clk, .rst_n, .csr_wr, .csr_rd, .csr_addr, .csr_wdata, .csr_rdata,
        .desc_push, .desc_out(desc_stage), .desc_full, .desc_empty, .data_empty,
        .stop, .rd_busy, .wr_busy, .done, .word_written
    );

    dma_fifo #(.WIDTH($bits(dma_desc_t)), .DEPTH(DESC_FIFO_DEPTH)) desc_fifo_inst (
        .clk, .rst_n, .push(desc_push), .wdata(desc_stage), .pop(desc_pop),
        .rdata(desc_head), .full(desc_full), .empty(desc_empty), .free()
    );

    // ==============================
    // Copy engines
    // ==============================
    dma_rd_src dma_rd_src_inst (
        .clk, .rst_n, .desc_in(desc_head), .desc_empty, .stop, .desc_pop,
        .cmd_push, .cmd_full, .rd_req, .rd_addr, .rd_gnt, .mem_rdata,
        .data_push, .data_wdata, .data_free, .busy(rd_busy)
    );

    // Popped descriptor goes on as the write command
    dma_fifo #(.WIDTH($bits(dma_desc_t)), .DEPTH(CMD_FIFO_DEPTH)) cmd_fifo_inst (
        .clk, .rst_n, .push(cmd_push), .wdata(desc_head), .pop(cmd_pop),
        .rdata(cmd_head), .full(cmd_full), .empty(cmd_empty), .free()
    );

    dma_fifo #(.WIDTH(DATA_W), .DEPTH(DATA_FIFO_DEPTH)) data_fifo_inst (
        .clk, .rst_n, .push(data_push), .wdata(data_wdata), .pop(data_pop),
        .rdata(data_head), .full(), .empty(data_empty), .free(data_free)
    );

    dma_wr_dest dma_wr_dest_inst (
        .clk, .rst_n, .cmd_in(cmd_head), .cmd_empty, .cmd_pop,
        .data_in(data_head), .data_empty, .data_pop, .wr_req, .wr_addr, .wr_data,
        .wr_gnt, .done, .word_written, .busy(wr_busy)
    );

    // Shared memory port
    dma_mem_arb dma_mem_arb_inst (
        .clk, .rst_n, .rd_req, .rd_addr, .rd_gnt, .wr_req, .wr_addr, .wr_data,
        .wr_gnt, .mem_en, .mem_we, .mem_addr, .mem_wdata
    );

endmodule
`default_nettype wire

// File: source/dma_wr_dest.sv
`default_nettype none
/* Write engine of the copy DMA. Pops a command, then drains the data
   FIFO to consecutive destination words and pulses done at the end */
module dma_wr_dest (
    input  wire                     clk,
    input  wire                     rst_n,
    // Command FIFO head
    input  wire dma_pkg::dma_desc_t cmd_in,
    input  wire                     cmd_empty,
    output logic                    cmd_pop,
    // Data FIFO head
    input  wire dma_pkg::data_t     data_in,
    input  wire                     data_empty,
    output logic                    data_pop,
    // Memory write request
    output logic                    wr_req,
    output dma_pkg::addr_t          wr_addr,
    output dma_pkg::data_t          wr_data,
    input  wire                     wr_gnt,
    // Completion
    output logic                    done,
    output logic                    word_written,
    output logic                    busy
);
    import dma_pkg::*;

    wr_state_t state_q;
    addr_t     addr_q;
    len_t      remain_q;
    logic      done_q;
    logic      wrote;

    assign cmd_pop = (state_q == WR_IDLE) && !cmd_empty;

    // One write per granted cycle while data is waiting
    assign wr_req  = (state_q == WR_COPY) && !data_empty;
    assign wr_addr = addr_q;
    assign wr_data = data_in;
    assign wrote   = wr_req && wr_gnt;

    assign data_pop     = wrote;
    assign word_written = wrote;
    assign done         = done_q;

    // Stay busy through a queued command and the done pulse
    assign busy = (state_q != WR_IDLE) || !cmd_empty || done_q;

    // ==============================
    // Write FSM
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= WR_IDLE;
            addr_q   <= '0;
            remain_q <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                WR_IDLE: begin
                    if (cmd_pop) begin
                        addr_q   <= cmd_in.dest;
                        remain_q <= cmd_in.len;
                        // Zero length finishes in the next cycle
                        if (cmd_in.len == '0) begin
                            done_q <= 1'b1;
                        end else begin
                            state_q <= WR_COPY;
                        end
                    end
                end
                WR_COPY: begin
                    if (wrote) begin
                        addr_q   <= addr_q + addr_t'(1);
                        remain_q <= remain_q - len_t'(1);
                        if (remain_q == len_t'(1)) begin
                            done_q  <= 1'b1;
                            state_q <= WR_IDLE;
                        end
                    end
                end
                default: state_q <= WR_IDLE;
            endcase
        end
    end

endmodule
`default_nettype wire

// File: test/dma_golden.txt
# M addr value = memory preset, D src dest len = descriptor, all hex; T n = test number
# E addr value = expected word after the test (hex), C done words = running counters (decimal)
T 1
C 0 0
T 2
M 0010 cafe0001
M 0011 cafe0002
D 0010 0200 0004
E 0200 cafe0001
E 0201 cafe0002
E 0202 a5a50012
E 0203 a5a50013
C 1 4
T 3
D 0020 0220 0002
D 0030 0230 0000
D 0040 0240 0001
D 0050 0250 0003
E 0220 a5a50020
E 0221 a5a50021
E 0230 a5a50230
E 0240 a5a50040
E 0250 a5a50050
E 0251 a5a50051
E 0252 a5a50052
C 5 10
T 4
D 0060 0260 0001
D 0061 0261 0001
D 0062 0262 0001
D 0063 0263 0001
D 0064 0264 0001
E 0260 a5a50060
E 0261 a5a50061
E 0262 a5a50062
E 0263 a5a50063
E 0264 a5a50264
C 9 14
T 5
D 0010 0300 0002
E 0300 cafe0001
E 0301 cafe0002
C 10 16
T 6
D 0100 0109 000b
E 0109 a5a50100
E 010a a5a50101
E 010b a5a50102
E 010c a5a50103
E 010d a5a50104
E 010e a5a50105
E 010f a5a50106
E 0110 a5a50107
E 0111 a5a50108
E 0112 a5a50100
E 0113 a5a50101
C 11 27

// File: test/tb_dma_top.sv
`default_nettype none
/* Self-checking testbench for the copy DMA. Replays test/dma_golden.txt
   against dma_top with a word-addressed memory model on the memory port */
module tb_dma_top;
    import dma_pkg::*;

    localparam int MEM_WORDS    = 1024;
    localparam int RESET_CYCLES = 16;
    // Status of a drained engine with overflow cleared
    localparam dma_status_t IDLE_STATUS = '{busy: 1'b0, desc_fifo_full: 1'b0,
        desc_fifo_empty: 1'b1, data_fifo_empty: 1'b1, overflow: 1'b0};

    logic      clk;
    logic      rst_n;
    logic      csr_wr;
    logic      csr_rd;
    csr_addr_t csr_addr;
    data_t     csr_wdata;
    data_t     csr_rdata;
    logic      mem_en;
    logic      mem_we;
    addr_t     mem_addr;
    data_t     mem_wdata;
    data_t     mem_rdata = '0;

    // Memory model and its power-on image
    data_t     mem [MEM_WORDS];
    data_t     init_mem [MEM_WORDS];

    // Golden content, tagged with the test index
    dma_desc_t desc_list [$];
    int        desc_tid [$];
    addr_t     exp_addr [$];
    data_t     exp_val [$];
    int        exp_tid [$];
    int        test_num [$];
    data_t     want_done [$];
    data_t     want_words [$];

    int        total_words;
    int        limit_cycles = 0;
    int        gap_cycles;
    int        errors;
    int        test_errors;
    int        tests_failed;

    dma_top dma_top_inst (
        .clk, .rst_n, .csr_wr, .csr_rd, .csr_addr, .csr_wdata, .csr_rdata,
        .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==============================
    // Memory model
    // ==============================
    // Image reloads during reset, read data comes one cycle after mem_en
    always @(posedge clk) begin : mem_model
        int i;
        if (!rst_n) begin
            for (i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= init_mem[i];
            end
        end else if (mem_en) begin
            if (mem_we) begin
                mem[mem_addr[9:0]] <= mem_wdata;
            end else begin
                mem_rdata <= mem[mem_addr[9:0]];
            end
        end
    end

    task automatic load_golden(output bit ok);
        int fd;
        int cur;
        int i;
        logic [7:0]       tag;
        logic [8*160-1:0] rest;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      c;
        dma_desc_t        d;
        ok = 1'b0;
        cur = -1;
        total_words = 0;
        // Background word differs at every address
        for (i = 0; i < MEM_WORDS; i++) begin
            init_mem[i] = 32'hA5A5_0000 | data_t'(i);
        end
        fd = $fopen("test/dma_golden.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fscanf(fd, " %s", tag) == 1) begin
                case (tag)
                    "#": void'($fgets(rest, fd));
                    "M": begin
                        void'($fscanf(fd, "%h %h", a, b));
                        init_mem[a[9:0]] = b;
                    end
                    "D": begin
                        void'($fscanf(fd, "%h %h %h", a, b, c));
                        d.src  = a[15:0];
                        d.dest = b[15:0];
                        d.len  = c[15:0];
                        desc_list.push_back(d);
                        desc_tid.push_back(cur);
                        total_words += int'(d.len);
                    end
                    "E": begin
                        void'($fscanf(fd, "%h %h", a, b));
                        exp_addr.push_back(a[15:0]);
                        exp_val.push_back(b);
                        exp_tid.push_back(cur);
                    end
                    "C": begin
                        void'($fscanf(fd, "%d %d", a, b));
                        want_done.push_back(a);
                        want_words.push_back(b);
                    end
                    "T": begin
                        void'($fscanf(fd, "%d", a));
                        cur++;
                        test_num.push_back(int'(a));
                    end
                    default: begin
                        $display("Golden file holds an unknown line tag");
                        ok = 1'b0;
                    end
                endcase
            end
            $fclose(fd);
        end
    endtask

    // ==============================
    // CSR bus and checks
    // ==============================
    task automatic write_csr(input csr_addr_t addr, input data_t value);
        @(posedge clk);
        csr_wr    <= 1'b1;
        csr_addr  <= addr;
        csr_wdata <= value;
        @(posedge clk);
        csr_wr <= 1'b0;
        repeat (gap_cycles) @(posedge clk);
    endtask

    task automatic read_csr(input csr_addr_t addr, output data_t value);
        @(posedge clk);
        csr_rd   <= 1'b1;
        csr_addr <= addr;
        @(posedge clk);
        csr_rd <= 1'b0;
        // Registered read data is stable by the falling edge
        @(negedge clk);
        value = csr_rdata;
    endtask

    task automatic check_value(input string name, input data_t got, input data_t want);
        if (got !== want) begin
            $display("FAILED at time %0t: %s is %h, expected %h", $time, name, got, want);
            errors++;
            test_errors++;
        end
    endtask

    // Stage one descriptor and fire go, stop kept as given
    task automatic queue_desc(input dma_desc_t d, input bit hold);
        write_csr(CSR_SRC, data_t'(d.src));
        write_csr(CSR_DEST, data_t'(d.dest));
        write_csr(CSR_LEN, data_t'(d.len));
        write_csr(CSR_CONTROL, (data_t'(hold) << CTRL_STOP_BIT) | (32'd1 << CTRL_GO_BIT));
    endtask

    // Poll status until nothing is queued or moving
    task automatic wait_idle();
        data_t       value;
        dma_status_t st;
        do begin
            read_csr(CSR_STATUS, value);
            st = dma_status_t'(value[4:0]);
        end while (st.busy || !st.desc_fifo_empty);
    endtask

    task automatic run_test(input int t);
        int          queued;
        bit          hold;
        data_t       value;
        dma_status_t st;
        addr_t       a;
        queued = 0;
        test_errors = 0;
        gap_cycles = int'($urandom % 4);
        foreach (desc_tid[i]) begin
            if (desc_tid[i] == t) queued++;
        end
        // More descriptors than FIFO entries means the stop and overflow case
        hold = (queued > DESC_FIFO_DEPTH);
        if (hold) write_csr(CSR_CONTROL, 32'd1 << CTRL_STOP_BIT);
        foreach (desc_tid[i]) begin
            if (desc_tid[i] == t) queue_desc(desc_list[i], hold);
        end
        if (hold) begin
            read_csr(CSR_STATUS, value);
            st = dma_status_t'(value[4:0]);
            check_value("status.desc_fifo_full", data_t'(st.desc_fifo_full), 32'd1);
            check_value("status.overflow", data_t'(st.overflow), 32'd1);
            // Release the held descriptors
            write_csr(CSR_CONTROL, 32'd0);
        end
        wait_idle();
        if (hold) begin
            // Sticky until software clears it
            read_csr(CSR_STATUS, value);
            st = dma_status_t'(value[4:0]);
            check_value("status.overflow", data_t'(st.overflow), 32'd1);
            write_csr(CSR_STATUS, 32'd0);
        end
        read_csr(CSR_STATUS, value);
        check_value("status", value, data_t'(IDLE_STATUS));
        read_csr(CSR_DONE_COUNT, value);
        check_value("done_count", value, want_done[t]);
        read_csr(CSR_WORD_COUNT, value);
        check_value("word_count", value, want_words[t]);
        foreach (exp_tid[i]) begin
            if (exp_tid[i] == t) begin
                a = exp_addr[i];
                check_value($sformatf("mem[%h]", a), mem[a[9:0]], exp_val[i]);
            end
        end
        if (test_errors != 0) tests_failed++;
        $display("Test %0d %s, gap %0d cycles, %0d errors", test_num[t],
                 (test_errors == 0) ? "passed" : "failed", gap_cycles, test_errors);
    endtask

    // ==============================
    // Run control
    // ==============================
    initial begin : main
        bit ok;
        rst_n     = 1'b0;
        csr_wr    = 1'b0;
        csr_rd    = 1'b0;
        csr_addr  = '0;
        csr_wdata = '0;
        errors       = 0;
        test_errors  = 0;
        tests_failed = 0;
        gap_cycles   = 0;
        void'($urandom(12));
        load_golden(ok);
        if (!ok) begin
            $display("Could not read the golden file, no tests run");
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            limit_cycles = 200 + 20 * total_words;
            repeat (RESET_CYCLES) @(posedge clk);
            rst_n <= 1'b1;
            foreach (test_num[t]) run_test(t);
            $display("Tests run %0d, tests failed %0d, mismatches %0d",
                     test_num.size(), tests_failed, errors);
            if (errors == 0) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
            $finish;
        end
    end

    // Budget grows with the copied word count
    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: tests still running after %0d clock cycles", limit_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
`default_nettype wire
